// ==== common/tcdm_pkg.sv ====
// ********************
// widths, depths and vector types of the TCDM queue subsystem
// ********************

package tcdm_pkg;

  // word addressed memory port
  localparam int unsigned ADDR_W     = 10;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned BE_W       = DATA_W / 8;  // one enable per byte
  localparam int unsigned MEM_WORDS  = 1 << ADDR_W;

  // default depth of both queues inside tcdm_fifo
  localparam int unsigned FIFO_DEPTH = 4;

  // request word as stored in the outgoing queue: {wen, be, wdata, addr}
  localparam int unsigned REQ_W      = ADDR_W + DATA_W + BE_W + 1;

  typedef logic [ADDR_W-1:0] addr_t;      // word address
  typedef logic [DATA_W-1:0] data_t;      // data word
  typedef logic [BE_W-1:0]   be_t;        // byte enables
  typedef logic [REQ_W-1:0]  req_word_t;  // packed request

endpackage

// ==== common/tcdm_if.sv ====
// ********************
// TCDM port with initiator and target views
// ********************

`timescale 1ns/1ps

interface tcdm_if import tcdm_pkg::*; ();

  // request channel
  logic  req;
  logic  gnt;
  addr_t addr;
  data_t wdata;
  be_t   be;
  logic  wen;     // high for read, low for write

  // response channel
  logic  r_valid;
  data_t r_data;
  logic  r_ready; // not honored by every target

  // side that issues requests
  modport initiator (
    output req,
    output addr,
    output wdata,
    output be,
    output wen,
    output r_ready,
    input  gnt,
    input  r_valid,
    input  r_data
  );

  // side that serves requests
  modport target (
    input  req,
    input  addr,
    input  wdata,
    input  be,
    input  wen,
    input  r_ready,
    output gnt,
    output r_valid,
    output r_data
  );

endinterface

// ==== tcdm_fifo/stream_fifo.sv ====
// ********************
// valid/ready stream queue with clear and empty flag
// ********************

`timescale 1ns/1ps

module stream_fifo #(
  parameter int unsigned DATA_WIDTH = 32,
  parameter int unsigned DEPTH      = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  push_valid_i,
  output logic                  push_ready_o,
  input  logic [DATA_WIDTH-1:0] push_data_i,
  output logic                  pop_valid_o,
  input  logic                  pop_ready_i,
  output logic [DATA_WIDTH-1:0] pop_data_o,
  output logic                  empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [DATA_WIDTH-1:0] buf_q [DEPTH];  // circular storage
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CNT_W-1:0]      count_q;        // occupancy
  logic                  push;
  logic                  pop;

  // pointer advance, wraps at DEPTH-1 so any depth works
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  assign push_ready_o = (count_q != CNT_W'(DEPTH)); // room left
  assign pop_valid_o  = (count_q != '0);
  assign empty_o      = (count_q == '0);
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_valid_o & pop_ready_i;

  // head entry comes straight from storage flops, never from push_data_i
  assign pop_data_o = buf_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;  // drop all entries
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;  // idle or push and pop together
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

// ==== tcdm_fifo/tcdm_fifo.sv ====
// ********************
// TCDM decoupling queue, request and response streams plus response skid
// ********************

`timescale 1ns/1ps

module tcdm_fifo import tcdm_pkg::*; #(
  parameter int unsigned DEPTH = FIFO_DEPTH
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   clear_i,
  output logic   empty_o,
  tcdm_if.target    tcdm_target,
  tcdm_if.initiator tcdm_initiator
);

  // outgoing stream, target requests toward memory
  req_word_t out_push_data;
  logic      out_push_ready;
  req_word_t out_pop_data;
  logic      out_pop_valid;
  logic      out_empty;

  // incoming stream, memory responses toward target
  data_t     in_push_data;
  logic      in_push_valid;
  logic      in_push_ready;
  logic      in_empty;

  // skid for a response that arrives while the incoming queue is full
  logic      skid_valid_q;
  data_t     skid_data_q;
  logic      skid_load;

  // pack target request
  assign out_push_data   = {tcdm_target.wen, tcdm_target.be, tcdm_target.wdata, tcdm_target.addr};
  assign tcdm_target.gnt = out_push_ready;  // full queue stalls the requester

  stream_fifo #(
    .DATA_WIDTH ( REQ_W ),
    .DEPTH      ( DEPTH )
  ) i_fifo_outgoing (
    .clk_i        ( clk_i              ),
    .rst_ni       ( rst_ni             ),
    .clear_i      ( clear_i            ),
    .push_valid_i ( tcdm_target.req    ),
    .push_ready_o ( out_push_ready     ),
    .push_data_i  ( out_push_data      ),
    .pop_valid_o  ( out_pop_valid      ),
    .pop_ready_i  ( tcdm_initiator.gnt ),
    .pop_data_o   ( out_pop_data       ),
    .empty_o      ( out_empty          )
  );

  // unpack toward memory
  assign {tcdm_initiator.wen, tcdm_initiator.be, tcdm_initiator.wdata,
          tcdm_initiator.addr} = out_pop_data;

  // only ask memory while a response has somewhere to go
  assign tcdm_initiator.req     = out_pop_valid & in_push_ready;
  assign tcdm_initiator.r_ready = in_push_ready;  // informative for the memory

  // held response goes first, a fresh one follows
  assign in_push_valid = skid_valid_q | tcdm_initiator.r_valid;
  assign in_push_data  = skid_valid_q ? skid_data_q : tcdm_initiator.r_data;

  // fresh response parks when it cannot be pushed this cycle
  assign skid_load = tcdm_initiator.r_valid & (skid_valid_q | ~in_push_ready);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      skid_valid_q <= 1'b0;
    end else if (clear_i) begin
      skid_valid_q <= 1'b0;
    end else begin
      skid_valid_q <= skid_load | (skid_valid_q & ~in_push_ready); // drains on push
    end
  end

  always_ff @(posedge clk_i) begin
    if (skid_load) begin
      skid_data_q <= tcdm_initiator.r_data;
    end
  end

  stream_fifo #(
    .DATA_WIDTH ( DATA_W ),
    .DEPTH      ( DEPTH  )
  ) i_fifo_incoming (
    .clk_i        ( clk_i                ),
    .rst_ni       ( rst_ni               ),
    .clear_i      ( clear_i              ),
    .push_valid_i ( in_push_valid        ),
    .push_ready_o ( in_push_ready        ),
    .push_data_i  ( in_push_data         ),
    .pop_valid_o  ( tcdm_target.r_valid  ),
    .pop_ready_i  ( tcdm_target.r_ready  ),
    .pop_data_o   ( tcdm_target.r_data   ),
    .empty_o      ( in_empty             )
  );

  // nothing queued, nothing parked
  assign empty_o = out_empty & in_empty & ~skid_valid_q;

endmodule

// ==== source/tcdm_memory.sv ====
// ********************
// single-port word memory, stall-throttled grant
// ********************

`timescale 1ns/1ps

module tcdm_memory import tcdm_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   stall_i,       // holds off grants while high
  tcdm_if.target tcdm_target
);

  data_t mem_q [MEM_WORDS];
  logic  gnt;
  logic  write_en;
  logic  r_valid_q;
  data_t r_data_q;

  assign gnt             = tcdm_target.req & ~stall_i;
  assign write_en        = gnt & ~tcdm_target.wen;  // wen low means write
  assign tcdm_target.gnt = gnt;

  // storage with byte merge on writes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (write_en) begin
      for (int b = 0; b < BE_W; b++) begin
        if (tcdm_target.be[b]) begin
          mem_q[tcdm_target.addr][b*8 +: 8] <= tcdm_target.wdata[b*8 +: 8];
        end
      end
    end
  end

  // every grant answered one cycle later, r_ready not consulted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= gnt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt) begin
      r_data_q <= tcdm_target.wen ? mem_q[tcdm_target.addr] : '0; // writes answer zero
    end
  end

  assign tcdm_target.r_valid = r_valid_q;
  assign tcdm_target.r_data  = r_data_q;

endmodule

// ==== source/tcdm_subsystem.sv ====
// ********************
// top level, TCDM queue in front of word memory
// ********************

`timescale 1ns/1ps

module tcdm_subsystem import tcdm_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,
  input  logic  mem_stall_i,
  // request side
  input  logic  req_i,
  output logic  gnt_o,
  input  addr_t addr_i,
  input  data_t wdata_i,
  input  be_t   be_i,
  input  logic  wen_i,       // high for read
  // response side
  output logic  r_valid_o,
  output data_t r_data_o,
  input  logic  r_ready_i,
  output logic  empty_o
);

  tcdm_if tcdm_up ();   // requester to queue
  tcdm_if tcdm_mem ();  // queue to memory

  // top ports onto the upstream port
  assign tcdm_up.req     = req_i;
  assign tcdm_up.addr    = addr_i;
  assign tcdm_up.wdata   = wdata_i;
  assign tcdm_up.be      = be_i;
  assign tcdm_up.wen     = wen_i;
  assign tcdm_up.r_ready = r_ready_i;
  assign gnt_o           = tcdm_up.gnt;
  assign r_valid_o       = tcdm_up.r_valid;
  assign r_data_o        = tcdm_up.r_data;

  tcdm_fifo #(
    .DEPTH ( FIFO_DEPTH )
  ) i_tcdm_fifo (
    .clk_i          ( clk_i    ),
    .rst_ni         ( rst_ni   ),
    .clear_i        ( clear_i  ),
    .empty_o        ( empty_o  ),
    .tcdm_target    ( tcdm_up  ),
    .tcdm_initiator ( tcdm_mem )
  );

  tcdm_memory i_tcdm_memory (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .stall_i     ( mem_stall_i ),
    .tcdm_target ( tcdm_mem    )
  );

endmodule

// ==== tests/tcdm_properties.sv ====
// ********************
// handshake assertions, bound to the top level
// ********************

`timescale 1ns/1ps

module tcdm_properties import tcdm_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  input logic  clear_i,
  input logic  req_i,
  input logic  gnt_i,
  input logic  r_valid_i,
  input data_t r_data_i,
  input logic  r_ready_i
);

  int unsigned assert_fails = 0;  // read by the testbench at the end

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(gnt_i) |-> req_i)
    else begin
      $error("gnt_o rose while req_i was low");
      assert_fails++;
    end

  // response must wait for r_ready unchanged
  r_valid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_i && !r_ready_i && !clear_i |=> r_valid_i && $stable(r_data_i))
    else begin
      $error("r_valid_o dropped or r_data_o changed before the response was taken");
      assert_fails++;
    end

  quiet_in_reset: assert property (@(posedge clk_i) !rst_ni |=> !r_valid_i)
    else begin
      $error("r_valid_o high right after a reset cycle");
      assert_fails++;
    end

  quiet_after_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clear_i |=> !r_valid_i)
    else begin
      $error("r_valid_o high in the cycle after clear_i");
      assert_fails++;
    end

endmodule

bind tcdm_subsystem tcdm_properties i_properties (
  .clk_i     ( clk_i     ),
  .rst_ni    ( rst_ni    ),
  .clear_i   ( clear_i   ),
  .req_i     ( req_i     ),
  .gnt_i     ( gnt_o     ),
  .r_valid_i ( r_valid_o ),
  .r_data_i  ( r_data_o  ),
  .r_ready_i ( r_ready_i )
);

// ==== tests/tcdm_checker.sv ====
// ********************
// reference memory and response order checker
// ********************

`timescale 1ns/1ps

module tcdm_checker import tcdm_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,
  input  logic  req_i,
  input  logic  gnt_i,
  input  addr_t addr_i,
  input  data_t wdata_i,
  input  be_t   be_i,
  input  logic  wen_i,
  input  logic  r_valid_i,
  input  data_t r_data_i,
  input  logic  r_ready_i,
  input  logic  done_i,
  output int    err_count_o,
  output int    pending_o
);

  typedef struct packed {
    logic  wen;
    be_t   be;
    data_t wdata;
    addr_t addr;
  } pend_t;

  data_t model_mem [MEM_WORDS] = '{default: '0};  // memory resets to zero
  pend_t pend_q [$];                              // accepted, not answered yet
  pend_t head;
  data_t expected;
  int    errs      = 0;
  int    n_pending = 0;
  bit    done_seen = 1'b0;

  assign err_count_o = errs;
  assign pending_o   = n_pending;

  function automatic data_t byte_merge(input data_t old, input data_t wdata, input be_t be);
    data_t res;
    res = old;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  // inputs settle 1 ns after the rising edge, so the falling edge sees a stable cycle
  always @(negedge clk_i) begin
    if (!rst_ni || clear_i) begin
      pend_q.delete();  // everything in flight is dropped
    end else begin
      if (r_valid_i && r_ready_i) begin
        if (pend_q.size() == 0) begin
          $display("response taken at %0t with no request outstanding", $time);
          errs++;
        end else begin
          head     = pend_q.pop_front();
          expected = head.wen ? model_mem[head.addr] : '0;
          // write lands in the model when its answer shows it reached memory
          if (!head.wen) begin
            model_mem[head.addr] = byte_merge(model_mem[head.addr], head.wdata, head.be);
          end
          if (r_data_i !== expected) begin
            $display("[ERROR] r_data_o expected 0x%08h actual 0x%08h", expected, r_data_i);
            errs++;
          end
        end
      end
      if (req_i && gnt_i) begin
        pend_q.push_back(pend_t'{wen_i, be_i, wdata_i, addr_i});
      end
    end
    if (done_i && !done_seen) begin
      done_seen = 1'b1;
      if (pend_q.size() != 0) begin
        $display("%0d responses still outstanding at end of run", pend_q.size());
        errs++;
      end
    end
    n_pending = pend_q.size();
  end

endmodule

// ==== tests/tcdm_tb.sv ====
// ********************
// testbench top, stimulus table, clock, reset, watchdog
// ********************

`timescale 1ns/1ps

module tcdm_tb import tcdm_pkg::*; ();

  localparam logic [1:0] STALL_NONE = 2'd0;
  localparam logic [1:0] STALL_HOLD = 2'd1;  // stall high for the first hold cycles
  localparam logic [1:0] STALL_RAND = 2'd2;
  localparam logic [1:0] RDY_ALWAYS = 2'd0;
  localparam logic [1:0] RDY_HOLD   = 2'd1;  // r_ready low for the first hold cycles
  localparam logic [1:0] RDY_RAND   = 2'd2;

  typedef struct packed {
    logic       drain;  // empty the pipeline before the row
    logic       wen;    // high for read
    addr_t      addr;
    data_t      wdata;
    be_t        be;
    logic [1:0] stall;
    logic [1:0] rdy;
    logic [7:0] hold;
    logic       clear;  // pulse clear_i once the row is granted
  } row_t;

  logic  clk_i;
  logic  rst_ni;
  logic  clear_i;
  logic  mem_stall_i;
  logic  req_i;
  logic  gnt_o;
  addr_t addr_i;
  data_t wdata_i;
  be_t   be_i;
  logic  wen_i;
  logic  r_valid_o;
  data_t r_data_o;
  logic  r_ready_i;
  logic  empty_o;
  logic  done;
  int    err_count;
  int    pending;

  row_t rows [$];
  int   tb_errors    = 0;
  int   limit        = 0;
  bit   rows_ready   = 1'b0;
  bit   gnt_low_seen = 1'b0;  // response back-pressure reached the requester

  tcdm_subsystem DUT (.*);

  tcdm_checker i_checker (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .clear_i     ( clear_i     ),
    .req_i       ( req_i       ),
    .gnt_i       ( gnt_o       ),
    .addr_i      ( addr_i      ),
    .wdata_i     ( wdata_i     ),
    .be_i        ( be_i        ),
    .wen_i       ( wen_i       ),
    .r_valid_i   ( r_valid_o   ),
    .r_data_i    ( r_data_o    ),
    .r_ready_i   ( r_ready_i   ),
    .done_i      ( done        ),
    .err_count_o ( err_count   ),
    .pending_o   ( pending     )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic add_row(input logic drain, input logic wen, input int addr, input data_t wdata,
                         input be_t be, input logic [1:0] stall, input logic [1:0] rdy,
                         input int hold, input logic clear);
    rows.push_back(row_t'{drain, wen, addr_t'(addr), wdata, be, stall, rdy, 8'(hold), clear});
  endtask

  task automatic build_table();
    // full and partial byte enables, then read back
    add_row(1'b0, 1'b0, 1, 32'h1122_3344, 4'hf, STALL_NONE, RDY_ALWAYS, 0, 1'b0);
    add_row(1'b0, 1'b0, 2, 32'h5566_7788, 4'hf, STALL_NONE, RDY_ALWAYS, 0, 1'b0);
    add_row(1'b0, 1'b0, 1, 32'hAABB_CCDD, 4'h5, STALL_NONE, RDY_ALWAYS, 0, 1'b0);
    add_row(1'b0, 1'b0, 2, 32'h9900_0000, 4'h8, STALL_NONE, RDY_ALWAYS, 0, 1'b0);
    add_row(1'b0, 1'b0, 3, 32'h0000_BEEF, 4'h3, STALL_NONE, RDY_ALWAYS, 0, 1'b0);
    for (int a = 1; a <= 3; a++) begin
      add_row(1'b0, 1'b1, a, '0, '0, STALL_NONE, RDY_ALWAYS, 0, 1'b0);
    end
    // memory stalled, outgoing queue fills
    for (int i = 0; i < 8; i++) begin
      add_row(i == 0, i >= 4, 48 + i % 4, 32'hA5A5_0000 + i, 4'hf, STALL_HOLD, RDY_ALWAYS,
              20, 1'b0);
    end
    // r_ready held off, response side backs up into gnt_o
    for (int i = 0; i < 12; i++) begin
      add_row(i == 0, i[0], 32 + i / 2, 32'h5A5A_0000 + i, 4'hf, STALL_NONE, RDY_HOLD,
              40, 1'b0);
    end
    // writes dropped by clear while stalled
    add_row(1'b1, 1'b0, 5, 32'hDEAD_BEEF, 4'hf, STALL_HOLD, RDY_ALWAYS, 60, 1'b0);
    add_row(1'b0, 1'b0, 6, 32'hCAFE_F00D, 4'hf, STALL_HOLD, RDY_ALWAYS, 60, 1'b1);
    add_row(1'b0, 1'b1, 5, '0, '0, STALL_NONE, RDY_ALWAYS, 0, 1'b0);
    add_row(1'b0, 1'b1, 6, '0, '0, STALL_NONE, RDY_ALWAYS, 0, 1'b0);
    // random traffic on a small address window
    for (int i = 0; i < 40; i++) begin
      add_row(1'b0, 1'($urandom), 64 + $urandom_range(15, 0), $urandom, 4'($urandom),
              STALL_RAND, RDY_RAND, 0, 1'b0);
    end
  endtask

  function automatic logic stall_at(input row_t r, input int k);
    case (r.stall)
      STALL_HOLD: return k < int'(r.hold);
      STALL_RAND: return $urandom_range(3, 0) == 0;  // one cycle in four
      default:    return 1'b0;
    endcase
  endfunction

  function automatic logic rdy_at(input row_t r, input int k);
    case (r.rdy)
      RDY_HOLD: return k >= int'(r.hold);
      RDY_RAND: return $urandom_range(1, 0) == 1;
      default:  return 1'b1;
    endcase
  endfunction

  // hold req_i and payload until gnt_o
  task automatic apply_row(input row_t r);
    int k;
    bit granted;
    k = 0;
    granted = 1'b0;
    while (!granted) begin
      @(posedge clk_i);
      #1;
      req_i       = 1'b1;
      wen_i       = r.wen;
      addr_i      = r.addr;
      wdata_i     = r.wdata;
      be_i        = r.be;
      mem_stall_i = stall_at(r, k);
      r_ready_i   = rdy_at(r, k);
      @(negedge clk_i);
      granted = gnt_o;
      if (!gnt_o && r.rdy == RDY_HOLD) begin
        gnt_low_seen = 1'b1;
      end
      k++;
    end
  endtask

  // a full outgoing queue keeps the last request up until gnt_o returns
  task automatic drain_pipeline();
    @(posedge clk_i);
    #1;
    mem_stall_i = 1'b0;
    r_ready_i   = 1'b1;
    while (!gnt_o) begin
      @(negedge clk_i);
      if (gnt_o) begin
        @(posedge clk_i);  // repeated request taken here
        #1;
      end
    end
    req_i = 1'b0;
    do begin
      @(posedge clk_i);
      #1;
    end while (pending != 0 || !empty_o);  // checker count covers the memory cycle
  endtask

  task automatic clear_queues();
    @(posedge clk_i);
    #1;
    req_i       = 1'b0;
    mem_stall_i = 1'b1;  // queued requests stay away from memory
    clear_i     = 1'b1;
    @(posedge clk_i);
    #1;
    clear_i = 1'b0;
    if (!empty_o) begin
      $display("empty_o still low in the cycle after clear_i");
      tb_errors++;
    end
  endtask

  initial begin
    wait (rows_ready);
    repeat (limit) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, run did not finish", limit);
    $display("Test failed");
    $finish;
  end

  initial begin
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    mem_stall_i = 1'b0;
    req_i       = 1'b0;
    addr_i      = '0;
    wdata_i     = '0;
    be_i        = '0;
    wen_i       = 1'b1;
    r_ready_i   = 1'b1;
    done        = 1'b0;
    void'($urandom(97187));
    build_table();
    limit      = rows.size() * 40 + 200;
    rows_ready = 1'b1;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    foreach (rows[i]) begin
      if (rows[i].drain) begin
        drain_pipeline();
      end
      apply_row(rows[i]);
      if (rows[i].clear) begin
        clear_queues();
      end
    end
    drain_pipeline();
    done = 1'b1;  // checker looks for leftovers
    repeat (2) @(posedge clk_i);
    if (!gnt_low_seen) begin
      $display("gnt_o never fell while r_ready_i was held low");
      tb_errors++;
    end
    $display("errors: checker %0d, testbench %0d, assertions %0d", err_count, tb_errors,
             DUT.i_properties.assert_fails);
    if (err_count + tb_errors + int'(DUT.i_properties.assert_fails) == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
common/tcdm_pkg.sv
common/tcdm_if.sv
tcdm_fifo/stream_fifo.sv
tcdm_fifo/tcdm_fifo.sv
source/tcdm_memory.sv
source/tcdm_subsystem.sv
tests/tcdm_properties.sv
tests/tcdm_checker.sv
tests/tcdm_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator and run, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tcdm_tb -o tcdm_sim \
  && ./obj_dir/tcdm_sim +verilator+error+limit+100 | tee /dev/stderr \
  | grep -q "^Test completed successfully$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
